/* flist.f */
+incdir+include
rtl/xbar_pkg.sv
rtl/rotate_pick.sv
rtl/channel_buffer.sv
rtl/bank_arbiter.sv
rtl/bank_dispatch.sv
rtl/xbar_core.sv
tb/tb_xbar_core.sv

/* Bender.yml */
package:
  name: xbar_core

sources:
  - files:
      - rtl/xbar_pkg.sv
      - rtl/rotate_pick.sv
      - rtl/channel_buffer.sv
      - rtl/bank_arbiter.sv
      - rtl/bank_dispatch.sv
      - rtl/xbar_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_xbar_core.sv

/* include/xbar_tb_tasks.svh */
task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
   if (got !== exp) begin
      $display("MISMATCH %s: got %0h, expected %0h", name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "value check");
   end
endtask

task automatic abort_run(input string why);
   $display("ERROR: %s", why);
   $display("Result: FAILED");
   $fatal(1, "run stopped");
endtask

// line-aligned byte address, bits 9:8 pick the bank
function automatic logic [31:0] make_addr(input int bank, input logic [31:0] tag);
   return {tag[31:10], 2'(bank), tag[7:4], 4'h0};
endfunction

function automatic line_data_t make_data(input logic [31:0] tag);
   return {tag, ~tag, tag ^ 32'h5a5a_a5a5, tag + 32'd1};
endfunction

function automatic int pending();
   int n = 0;
   for (int c = 0; c < NUM_CH; c++)
      for (int b = 0; b < NUM_BANKS; b++)
         n += htu_q[c][b].size() + wbuf_q[c][b].size();
   return n;
endfunction

task automatic wait_drained();
   while (pending() != 0) @(negedge clk);
   repeat (2) @(negedge clk);           // last slots get reclaimed
endtask

// starts on a falling edge, returns on the falling edge after the handshake
task automatic send(input int c, input op_t op, input logic [31:0] baddr,
                    input line_data_t data);
   ch_valid[c] = 1'b1;
   ch_op[c]    = op;
   ch_addr[c]  = baddr[31:4];
   ch_data[c]  = data;
   while (!ch_ready[c]) @(negedge clk);  // ready ignores valid
   htu_q[c][baddr[9:8]].push_back({op, baddr, data});   // taken on the next edge
   wbuf_q[c][baddr[9:8]].push_back({op, baddr, data});
   @(negedge clk);
   ch_valid[c] = 1'b0;
endtask

task automatic take_htu(input int b);
   int c;
   logic [161:0] e;
   logic [31:0] a;
   c = htu_channel_id[b];
   if (c >= NUM_CH || htu_q[c][b].size() == 0)
      abort_run($sformatf("hit-test port of bank %0d sent an unexpected request (channel %0d)",
                          b, c));
   else begin
      e = htu_q[c][b].pop_front();       // oldest for this channel and bank
      a = e[159:128];
      check($sformatf("htu_op[%0d]", b), htu_op[b], e[161:160]);
      check($sformatf("htu_addr[%0d]", b), htu_addr[b], a[31:4]);
      check($sformatf("htu_set[%0d]", b), htu_set[b], a[7:5]);
      htu_cnt[b]++;
      fire_log.push_back({2'(b), 2'(c)});
   end
endtask

task automatic take_wbuf(input int b);
   int c;
   logic [161:0] e;
   c = wbuf_channel_id[b];
   if (c >= NUM_CH || wbuf_q[c][b].size() == 0)
      abort_run($sformatf("write-buffer port of bank %0d sent an unexpected request", b));
   else begin
      e = wbuf_q[c][b].pop_front();
      check($sformatf("wbuf_data[%0d]", b), wbuf_data[b], e[127:0]);
   end
endtask

task automatic test_routing();
   @(negedge clk);
   send(1, 2'd1, 32'h1234_5ae0, make_data(32'hc0ff_ee01));   // bank 2, set 7
   while (htu_valid == '0 && wbuf_valid == '0) @(negedge clk);
   // both sides at once, bank 2 only
   check("htu_valid", htu_valid, 4'b0100);
   check("wbuf_valid", wbuf_valid, 4'b0100);
   check("htu_channel_id[2]", htu_channel_id[2], 1);
   check("wbuf_channel_id[2]", wbuf_channel_id[2], 1);
   wait_drained();
endtask

task automatic test_order();
   int banks [8] = '{1, 0, 3, 0, 0, 1, 1, 3};
   htu_ready[1]  = 1'b0;                // bank 1 pins the oldest slot
   wbuf_ready[1] = 1'b0;
   for (int i = 0; i < 8; i++) begin
      if (i == 4) begin
         repeat (6) @(negedge clk);      // banks 0 and 3 finish first
         htu_ready[1]  = 1'b1;
         wbuf_ready[1] = 1'b1;
      end
      send(0, op_t'(i), make_addr(banks[i], 32'h4000_0000 + i * 32'h0011_0040),
           make_data(32'hd000_0000 + i));
   end
   wait_drained();
endtask

task automatic test_round_robin();
   int exp_order [3] = '{1, 2, 0};      // pointer sits at 0, search starts after it
   for (int r = 0; r < 2; r++) begin
      htu_ready[3]  = 1'b0;
      wbuf_ready[3] = 1'b0;
      fire_log.delete();
      fork                                // same edge on all three channels
         send(0, 2'd0, make_addr(3, 32'h5000_0100 + r), make_data(32'h0a00 + r));
         send(1, 2'd1, make_addr(3, 32'h5100_0200 + r), make_data(32'h1a00 + r));
         send(2, 2'd2, make_addr(3, 32'h5200_0300 + r), make_data(32'h2a00 + r));
      join
      repeat (4) @(negedge clk);
      htu_ready[3]  = 1'b1;
      wbuf_ready[3] = 1'b1;
      wait_drained();
      for (int i = 0; i < 3; i++)
         check("htu_channel_id[3] order", fire_log[i], {2'd3, 2'(exp_order[i])});
   end
endtask

task automatic test_fork_backpressure();
   int base;
   line_data_t d_a;
   d_a  = make_data(32'ha0a0_0001);
   base = htu_cnt[0];
   wbuf_ready[0] = 1'b0;                // hit-test side free, write buffer stalled
   send(2, 2'd1, make_addr(0, 32'h1111_1000), d_a);
   send(2, 2'd3, make_addr(0, 32'h2222_2000), make_data(32'hb0b0_0002));
   while (htu_cnt[0] == base) @(negedge clk);
   repeat (4) begin
      check("htu_valid[0]", htu_valid[0], 0);
      check("wbuf_valid[0]", wbuf_valid[0], 1);
      check("wbuf_data[0]", wbuf_data[0], d_a);   // payload holds
      @(negedge clk);
   end
   wbuf_ready[0] = 1'b1;
   wait_drained();
endtask

task automatic test_channel_full();
   htu_ready[1]  = 1'b0;
   wbuf_ready[1] = 1'b0;
   for (int i = 0; i < DEPTH; i++)
      send(0, op_t'(i), make_addr(1, 32'h3000_0000 + i * 32'h1230), make_data(32'he0 + i));
   repeat (3) begin
      check("ch_ready[0]", ch_ready[0], 0);
      @(negedge clk);
   end
   htu_ready[1]  = 1'b1;
   wbuf_ready[1] = 1'b1;
   wait_drained();
   while (!ch_ready[0]) @(negedge clk);  // slots come back
endtask

task automatic send_stream(input int c);
   logic [31:0] a;
   int gap;
   repeat (N_RAND) begin
      a   = $random(seed);
      gap = {$random(seed)} % 3;
      repeat (gap) @(negedge clk);
      send(c, op_t'($random(seed)), {a[31:4], 4'h0}, make_data($random(seed)));
   end
endtask

task automatic test_random();
   logic streams_done;
   streams_done = 1'b0;
   fork
      begin
         fork
            send_stream(0);
            send_stream(1);
            send_stream(2);
         join
         streams_done = 1'b1;
      end
      while (!streams_done) begin
         @(negedge clk);
         htu_ready  = 4'($random(seed));
         wbuf_ready = 4'($random(seed));
      end
   join
   htu_ready  = '1;
   wbuf_ready = '1;
   wait_drained();
endtask

/* tb/tb_xbar_core.sv */
`timescale 1ns/1ps

module tb_xbar_core import xbar_pkg::*; ();

   localparam int NUM_CH    = 3;
   localparam int NUM_BANKS = 4;
   localparam int DEPTH     = 5;
   localparam int N_RAND    = 60;       // requests per channel in the random test
   // directed tests need a few hundred cycles, random traffic gets 40 per request
   localparam int TIMEOUT_CYCLES = 1000 + N_RAND * NUM_CH * 40;

   logic                          clk;
   logic                          rstn;
   logic       [NUM_CH-1:0]       ch_valid;
   logic       [NUM_CH-1:0]       ch_ready;
   op_t        [NUM_CH-1:0]       ch_op;
   line_addr_t [NUM_CH-1:0]       ch_addr;
   line_data_t [NUM_CH-1:0]       ch_data;
   logic       [NUM_BANKS-1:0]    htu_valid;
   logic       [NUM_BANKS-1:0]    htu_ready;
   chan_id_t   [NUM_BANKS-1:0]    htu_channel_id;
   op_t        [NUM_BANKS-1:0]    htu_op;
   line_addr_t [NUM_BANKS-1:0]    htu_addr;
   set_t       [NUM_BANKS-1:0]    htu_set;
   logic       [NUM_BANKS-1:0]    wbuf_valid;
   logic       [NUM_BANKS-1:0]    wbuf_ready;
   chan_id_t   [NUM_BANKS-1:0]    wbuf_channel_id;
   line_data_t [NUM_BANKS-1:0]    wbuf_data;

   integer       seed = 80749;
   int           cycles = 0;
   // expected requests per channel and bank, {op, byte addr, data}
   logic [161:0] htu_q  [NUM_CH][NUM_BANKS][$];
   logic [161:0] wbuf_q [NUM_CH][NUM_BANKS][$];
   int           htu_cnt  [NUM_BANKS] = '{default: 0};    // hit-test handshakes seen
   logic [3:0]   fire_log [$];         // {bank, channel} per hit-test handshake

   `include "xbar_tb_tasks.svh"

   xbar_core #(
      .NUM_CH     (NUM_CH),
      .NUM_BANKS  (NUM_BANKS),
      .DEPTH      (DEPTH)
   ) u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES)
         abort_run($sformatf("timeout, run still busy after %0d cycles", TIMEOUT_CYCLES));
   end

   // egress monitor, one check per handshake
   always @(posedge clk) begin
      if (rstn) begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            if (htu_valid[b] && htu_ready[b])
               take_htu(b);
            if (wbuf_valid[b] && wbuf_ready[b])
               take_wbuf(b);
         end
      end
   end

   initial begin
      rstn       = 1'b0;
      ch_valid   = '0;
      ch_op      = '0;
      ch_addr    = '0;
      ch_data    = '0;
      htu_ready  = '0;
      wbuf_ready = '0;
      repeat (3) @(posedge clk);        // three cycles in reset
      @(negedge clk);
      rstn = 1'b1;
      check("ch_ready", ch_ready, 3'b111);
      check("htu_valid", htu_valid, 0);
      check("wbuf_valid", wbuf_valid, 0);
      htu_ready  = '1;
      wbuf_ready = '1;
      test_routing();
      test_order();
      test_round_robin();
      test_fork_backpressure();
      test_channel_full();
      test_random();
      if (pending() != 0)
         abort_run("requests were accepted but never delivered");
      else begin
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

/* rtl/xbar_core.sv */
`timescale 1ns/1ps

// request crossbar, NUM_CH producers to NUM_BANKS banks
// bank chosen by byte address bits 9:8
module xbar_core import xbar_pkg::*; #(
   parameter int NUM_CH    = 3,
   parameter int NUM_BANKS = 4,
   parameter int DEPTH     = 5
) (
   input  logic                          clk,
   input  logic                          rstn,
   // ingress, one lane per channel
   input  logic       [NUM_CH-1:0]       ch_valid,
   output logic       [NUM_CH-1:0]       ch_ready,
   input  op_t        [NUM_CH-1:0]       ch_op,
   input  line_addr_t [NUM_CH-1:0]       ch_addr,
   input  line_data_t [NUM_CH-1:0]       ch_data,
   // hit-test egress, one lane per bank
   output logic       [NUM_BANKS-1:0]    htu_valid,
   input  logic       [NUM_BANKS-1:0]    htu_ready,
   output chan_id_t   [NUM_BANKS-1:0]    htu_channel_id,
   output op_t        [NUM_BANKS-1:0]    htu_op,
   output line_addr_t [NUM_BANKS-1:0]    htu_addr,
   output set_t       [NUM_BANKS-1:0]    htu_set,
   // write-buffer egress
   output logic       [NUM_BANKS-1:0]    wbuf_valid,
   input  logic       [NUM_BANKS-1:0]    wbuf_ready,
   output chan_id_t   [NUM_BANKS-1:0]    wbuf_channel_id,
   output line_data_t [NUM_BANKS-1:0]    wbuf_data
);

   // channel-major, as the buffers see it
   logic       [NUM_CH-1:0][NUM_BANKS-1:0]   cb_req_valid;
   op_t        [NUM_CH-1:0][NUM_BANKS-1:0]   cb_req_op;
   line_addr_t [NUM_CH-1:0][NUM_BANKS-1:0]   cb_req_addr;
   line_data_t [NUM_CH-1:0][NUM_BANKS-1:0]   cb_req_data;
   logic       [NUM_CH-1:0][NUM_BANKS-1:0]   cb_grant;

   // bank-major, as the arbiters see it
   logic       [NUM_BANKS-1:0][NUM_CH-1:0]   ba_req_valid;
   op_t        [NUM_BANKS-1:0][NUM_CH-1:0]   ba_req_op;
   line_addr_t [NUM_BANKS-1:0][NUM_CH-1:0]   ba_req_addr;
   line_data_t [NUM_BANKS-1:0][NUM_CH-1:0]   ba_req_data;
   logic       [NUM_BANKS-1:0][NUM_CH-1:0]   ba_grant;

   for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
      channel_buffer #(
         .NUM_BANKS  (NUM_BANKS),
         .DEPTH      (DEPTH)
      ) u_buf (
         .clk        (clk),
         .rstn       (rstn),
         .in_valid   (ch_valid[c]),
         .in_ready   (ch_ready[c]),
         .in_op      (ch_op[c]),
         .in_addr    (ch_addr[c]),
         .in_data    (ch_data[c]),
         .req_valid  (cb_req_valid[c]),
         .req_op     (cb_req_op[c]),
         .req_addr   (cb_req_addr[c]),
         .req_data   (cb_req_data[c]),
         .grant      (cb_grant[c])
      );

      // transpose, requests out to banks and grants back in
      for (genvar b = 0; b < NUM_BANKS; b++) begin : g_xp
         assign ba_req_valid[b][c] = cb_req_valid[c][b];
         assign ba_req_op[b][c]    = cb_req_op[c][b];
         assign ba_req_addr[b][c]  = cb_req_addr[c][b];
         assign ba_req_data[b][c]  = cb_req_data[c][b];
         assign cb_grant[c][b]     = ba_grant[b][c];
      end
   end

   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      logic         sel_valid;
      chan_id_t     sel_channel;
      op_t          sel_op;
      line_addr_t   sel_addr;
      line_data_t   sel_data;
      logic         sel_done;

      bank_arbiter #(
         .NUM_CH       (NUM_CH),
         .DEPTH        (DEPTH)
      ) u_arb (
         .clk          (clk),
         .rstn         (rstn),
         .req_valid    (ba_req_valid[b]),
         .req_op       (ba_req_op[b]),
         .req_addr     (ba_req_addr[b]),
         .req_data     (ba_req_data[b]),
         .grant        (ba_grant[b]),
         .sel_valid    (sel_valid),
         .sel_channel  (sel_channel),
         .sel_op       (sel_op),
         .sel_addr     (sel_addr),
         .sel_data     (sel_data),
         .sel_done     (sel_done)
      );

      bank_dispatch u_disp (
         .clk              (clk),
         .rstn             (rstn),
         .sel_valid        (sel_valid),
         .sel_channel      (sel_channel),
         .sel_op           (sel_op),
         .sel_addr         (sel_addr),
         .sel_data         (sel_data),
         .sel_done         (sel_done),
         .htu_valid        (htu_valid[b]),
         .htu_ready        (htu_ready[b]),
         .htu_channel_id   (htu_channel_id[b]),
         .htu_op           (htu_op[b]),
         .htu_addr         (htu_addr[b]),
         .htu_set          (htu_set[b]),
         .wbuf_valid       (wbuf_valid[b]),
         .wbuf_ready       (wbuf_ready[b]),
         .wbuf_channel_id  (wbuf_channel_id[b]),
         .wbuf_data        (wbuf_data[b])
      );
   end

endmodule

/* rtl/bank_dispatch.sv */
`timescale 1ns/1ps

// forks one selected request to hit-test and write buffer
// retires once both sides have taken it
module bank_dispatch import xbar_pkg::*; (
   input  logic         clk,
   input  logic         rstn,
   // from the arbiter
   input  logic         sel_valid,
   input  chan_id_t     sel_channel,
   input  op_t          sel_op,
   input  line_addr_t   sel_addr,
   input  line_data_t   sel_data,
   output logic         sel_done,
   // hit-test side
   output logic         htu_valid,
   input  logic         htu_ready,
   output chan_id_t     htu_channel_id,
   output op_t          htu_op,
   output line_addr_t   htu_addr,
   output set_t         htu_set,
   // write-buffer side
   output logic         wbuf_valid,
   input  logic         wbuf_ready,
   output chan_id_t     wbuf_channel_id,
   output line_data_t   wbuf_data
);

   logic htu_sent;      // hit-test already took this request
   logic wbuf_sent;     // write buffer already took it
   logic htu_fire;
   logic wbuf_fire;

   assign htu_valid  = sel_valid && !htu_sent;
   assign wbuf_valid = sel_valid && !wbuf_sent;
   assign htu_fire   = htu_valid && htu_ready;
   assign wbuf_fire  = wbuf_valid && wbuf_ready;

   // both sides may accept in the same cycle
   assign sel_done = sel_valid && (htu_sent || htu_fire) && (wbuf_sent || wbuf_fire);

   assign htu_channel_id  = sel_channel;
   assign htu_op          = sel_op;
   assign htu_addr        = sel_addr;
   assign htu_set         = sel_addr[SET_LSB +: $bits(set_t)];   // byte bits 7:5
   assign wbuf_channel_id = sel_channel;
   assign wbuf_data       = sel_data;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         htu_sent  <= 1'b0;
         wbuf_sent <= 1'b0;
      end else if (sel_done) begin
         htu_sent  <= 1'b0;           // retired, ready for the next one
         wbuf_sent <= 1'b0;
      end else begin
         if (htu_fire)
            htu_sent <= 1'b1;
         if (wbuf_fire)
            wbuf_sent <= 1'b1;
      end
   end

endmodule

/* rtl/bank_arbiter.sv */
`timescale 1ns/1ps

// round robin over channels for one bank
// a selection, once shown, holds until it retires
module bank_arbiter import xbar_pkg::*; #(
   parameter int NUM_CH = 3,
   parameter int DEPTH  = 5
) (
   input  logic                       clk,
   input  logic                       rstn,
   // oldest request of each channel for this bank
   input  logic       [NUM_CH-1:0]    req_valid,
   input  op_t        [NUM_CH-1:0]    req_op,
   input  line_addr_t [NUM_CH-1:0]    req_addr,
   input  line_data_t [NUM_CH-1:0]    req_data,
   output logic       [NUM_CH-1:0]    grant,
   // to the dispatch fork
   output logic                       sel_valid,
   output chan_id_t                   sel_channel,
   output op_t                        sel_op,
   output line_addr_t                 sel_addr,
   output line_data_t                 sel_data,
   input  logic                       sel_done
);

   // finder index is sized for the wider of slots and channels
   localparam int PICK_W = $clog2((DEPTH > NUM_CH) ? DEPTH : NUM_CH);

   chan_id_t            last_ch;       // last retired channel
   chan_id_t            held_ch;       // channel of the selection in flight
   logic                busy;          // selection shown, not yet retired
   logic                rr_found;
   entry_id_t           rr_pick;
   logic [PICK_W-1:0]   rr_idx;
   chan_id_t            next_ch;

   // search starts after the pointer, so the pointer itself comes last
   rotate_pick #(
      .WIDTH      (NUM_CH),
      .SKIP_START (1)
   ) u_rr (
      .start      (entry_id_t'(last_ch)),
      .valid_vec  (req_valid),
      .found      (rr_found),
      .pick       (rr_pick)
   );

   assign rr_idx  = rr_pick[PICK_W-1:0];
   assign next_ch = chan_id_t'(rr_idx);

   // late requests from other channels can't steal a held pick
   assign sel_channel = busy ? held_ch : next_ch;
   assign sel_valid   = busy ? req_valid[held_ch] : rr_found;
   assign sel_op      = req_op[sel_channel];
   assign sel_addr    = req_addr[sel_channel];
   assign sel_data    = req_data[sel_channel];

   // one-cycle grant back to the winning channel on retire
   always_comb begin
      for (int c = 0; c < NUM_CH; c++) begin
         grant[c] = sel_done && (sel_channel == chan_id_t'(c));
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         last_ch <= '0;
         busy    <= 1'b0;
      end else if (sel_done) begin
         last_ch <= sel_channel;              // pointer moves only on retire
         busy    <= 1'b0;
      end else if (sel_valid) begin
         busy    <= 1'b1;                     // stalled, freeze the choice
      end
   end

   always_ff @(posedge clk) begin
      if (!busy)
         held_ch <= next_ch;
   end

endmodule

/* rtl/channel_buffer.sv */
`timescale 1ns/1ps

// per-channel request store
// entries leave out of order across banks, slots come back in order
module channel_buffer import xbar_pkg::*; #(
   parameter int NUM_BANKS = 4,
   parameter int DEPTH     = 5
) (
   input  logic                          clk,
   input  logic                          rstn,
   // producer side
   input  logic                          in_valid,
   output logic                          in_ready,
   input  op_t                           in_op,
   input  line_addr_t                    in_addr,
   input  line_data_t                    in_data,
   // one request per bank, oldest first
   output logic       [NUM_BANKS-1:0]    req_valid,
   output op_t        [NUM_BANKS-1:0]    req_op,
   output line_addr_t [NUM_BANKS-1:0]    req_addr,
   output line_data_t [NUM_BANKS-1:0]    req_data,
   input  logic       [NUM_BANKS-1:0]    grant
);

   localparam int CNT_W = $clog2(DEPTH + 1);

   // slot storage
   op_t                    mem_op   [DEPTH];
   line_addr_t             mem_addr [DEPTH];
   line_data_t             mem_data [DEPTH];
   logic [BANK_BITS-1:0]   slot_bank [DEPTH];     // bank tag, latched at write
   logic [DEPTH-1:0]       slot_valid;            // still waiting for its bank

   entry_id_t              wptr;
   entry_id_t              rptr;                  // oldest slot in use
   logic [CNT_W-1:0]       used_cnt;

   logic                   push;
   logic                   reclaim;

   logic [NUM_BANKS-1:0][DEPTH-1:0] bank_vec;     // valid slots per bank
   entry_id_t              oldest [NUM_BANKS];

   assign in_ready = (used_cnt < DEPTH);          // independent of in_valid
   assign push     = in_valid && in_ready;

   // head slot already retired by every bank, free it
   assign reclaim  = (used_cnt != '0) && !slot_valid[rptr];

   // payload, written on the accepting edge
   always_ff @(posedge clk) begin
      if (push) begin
         mem_op[wptr]    <= in_op;
         mem_addr[wptr]  <= in_addr;
         mem_data[wptr]  <= in_data;
         slot_bank[wptr] <= in_addr[BANK_LSB +: BANK_BITS];
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         slot_valid <= '0;
         wptr       <= '0;
         rptr       <= '0;
         used_cnt   <= '0;
      end else begin
         // grants hit different slots, one per bank at most
         for (int b = 0; b < NUM_BANKS; b++) begin
            if (grant[b])
               slot_valid[oldest[b]] <= 1'b0;
         end
         if (push) begin
            slot_valid[wptr] <= 1'b1;             // wptr never points at a live slot
            wptr <= (wptr == entry_id_t'(DEPTH - 1)) ? '0 : wptr + 1'b1;
         end
         if (reclaim)
            rptr <= (rptr == entry_id_t'(DEPTH - 1)) ? '0 : rptr + 1'b1;
         case ({push, reclaim})
            2'b10:   used_cnt <= used_cnt + 1'b1;
            2'b01:   used_cnt <= used_cnt - 1'b1;
            default: used_cnt <= used_cnt;        // none, or one in and one out
         endcase
      end
   end

   // split the valid bits by bank tag
   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int s = 0; s < DEPTH; s++) begin
            bank_vec[b][s] = slot_valid[s] && (slot_bank[s] == BANK_BITS'(b));
         end
      end
   end

   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      // scan from rptr, first hit is the oldest for this bank
      rotate_pick #(
         .WIDTH      (DEPTH),
         .SKIP_START (0)
      ) u_oldest (
         .start      (rptr),
         .valid_vec  (bank_vec[b]),
         .found      (req_valid[b]),
         .pick       (oldest[b])
      );

      assign req_op[b]   = mem_op[oldest[b]];
      assign req_addr[b] = mem_addr[oldest[b]];
      assign req_data[b] = mem_data[oldest[b]];
   end

endmodule

/* rtl/rotate_pick.sv */
`timescale 1ns/1ps

// circular first-one finder
// SKIP_START 0 looks at start first (oldest entry from the read pointer)
// SKIP_START 1 looks at start last (round robin after the last winner)
module rotate_pick import xbar_pkg::*; #(
   parameter int WIDTH      = 5,
   parameter int SKIP_START = 0
) (
   input  entry_id_t          start,
   input  logic [WIDTH-1:0]   valid_vec,
   output logic               found,
   output entry_id_t          pick
);

   always_comb begin
      int pos;
      found = 1'b0;
      pick  = '0;                               // don't care when nothing found
      for (int i = 0; i < WIDTH; i++) begin
         // true modulo scan, no padding to a power of two
         pos = (int'(start) + i + SKIP_START) % WIDTH;
         if (!found && valid_vec[pos]) begin
            found = 1'b1;
            pick  = entry_id_t'(pos);
         end
      end
   end

endmodule

/* rtl/xbar_pkg.sv */
package xbar_pkg;

   // request payload as it sits in a channel buffer
   typedef logic [27:0]  line_addr_t;   // byte address bits 31:4
   typedef logic [127:0] line_data_t;   // one cache line of write data

   // op codes ride through the crossbar untouched
   // 0 read, 1 write, 2 flush, 3 invalidate
   typedef logic [1:0]   op_t;

   typedef logic [2:0]   set_t;         // byte address bits 7:5
   typedef logic [1:0]   chan_id_t;     // producer channel number
   typedef logic [2:0]   entry_id_t;    // buffer slot index, also finder index

   // field positions inside line_addr_t
   // line_addr_t bit 0 is byte address bit 4
   localparam int BANK_LSB  = 4;        // byte bit 8
   localparam int BANK_BITS = 2;        // byte bits 9:8 pick one of four banks
   localparam int SET_LSB   = 1;        // byte bit 5

endpackage
